/* design/tcdm_pkg.sv */
// word width is fixed at 32 bits and the adapter is built for that width only
// op codes 10 to 15 are reserved and must not be issued by the core
package tcdm_pkg;

  // ------------------------------------------------------------
  // data path widths
  // ------------------------------------------------------------

  // one bank word
  localparam int unsigned DataWidth = 32;

  // one enable per byte of the word
  localparam int unsigned BeWidth = DataWidth / 8;

  // width of the atomic op code field on the core side
  localparam int unsigned AmoWidth = 4;

  // ------------------------------------------------------------
  // atomic op codes
  // ------------------------------------------------------------

  // none marks a plain load or store
  // swap to minu are read-modify-write atomics returning the old word
  typedef enum logic [AmoWidth-1:0] {
    amo_none = 4'h0,
    amo_swap = 4'h1,
    amo_add  = 4'h2,
    amo_and  = 4'h3,
    amo_or   = 4'h4,
    amo_xor  = 4'h5,
    amo_max  = 4'h6,
    amo_maxu = 4'h7,
    amo_min  = 4'h8,
    amo_minu = 4'h9
  } amo_op_e;

endpackage

/* design/amo_alu.sv */
// purely combinational, result is valid in the cycle the old word arrives
// reserved op codes and amo_none give an all-zero result
`timescale 1ns/1ps

module amo_alu (
  input  tcdm_pkg::amo_op_e                amo_op_i,
  input  logic [tcdm_pkg::DataWidth-1:0]   operand_mem_i,
  input  logic [tcdm_pkg::DataWidth-1:0]   operand_req_i,
  output logic [tcdm_pkg::DataWidth-1:0]   result_o
);

  // ------------------------------------------------------------
  // shared adder
  // ------------------------------------------------------------

  // one bit wider than the word so the compare sign is never lost
  logic [tcdm_pkg::DataWidth:0] adder_a;
  logic [tcdm_pkg::DataWidth:0] adder_b;
  logic [tcdm_pkg::DataWidth:0] adder_sum;

  // subtract for all compare ops
  logic sub;
  // sign extend for max and min, zero extend for maxu and minu
  logic signed_cmp;
  // memory word is smaller than the request operand
  logic mem_less;

  always_comb begin
    sub        = amo_op_i inside {tcdm_pkg::amo_max, tcdm_pkg::amo_min,
                                  tcdm_pkg::amo_maxu, tcdm_pkg::amo_minu};
    signed_cmp = amo_op_i inside {tcdm_pkg::amo_max, tcdm_pkg::amo_min};

    // extension bit is the msb for signed compares, else zero
    adder_a = {signed_cmp & operand_mem_i[tcdm_pkg::DataWidth-1], operand_mem_i};
    adder_b = {signed_cmp & operand_req_i[tcdm_pkg::DataWidth-1], operand_req_i};

    // two's complement of b via inversion plus carry in
    if (sub) begin
      adder_b = ~adder_b;
    end
  end

  assign adder_sum = adder_a + adder_b + {{tcdm_pkg::DataWidth{1'b0}}, sub};

  // the 33 bit difference always fits, so its top bit is the sign
  assign mem_less = adder_sum[tcdm_pkg::DataWidth];

  // ------------------------------------------------------------
  // result select
  // ------------------------------------------------------------

  always_comb begin
    case (amo_op_i)
      // new word is just the request operand
      tcdm_pkg::amo_swap: result_o = operand_req_i;
      // sum wraps modulo 2^32
      tcdm_pkg::amo_add:  result_o = adder_sum[tcdm_pkg::DataWidth-1:0];
      tcdm_pkg::amo_and:  result_o = operand_mem_i & operand_req_i;
      tcdm_pkg::amo_or:   result_o = operand_mem_i | operand_req_i;
      tcdm_pkg::amo_xor:  result_o = operand_mem_i ^ operand_req_i;
      // keep the larger one
      tcdm_pkg::amo_max,
      tcdm_pkg::amo_maxu: result_o = mem_less ? operand_req_i : operand_mem_i;
      // keep the smaller one
      tcdm_pkg::amo_min,
      tcdm_pkg::amo_minu: result_o = mem_less ? operand_mem_i : operand_req_i;
      default:            result_o = '0;
    endcase
  end

endmodule

/* design/amo_sequencer.sv */
// expects exclusive bank access, atomics block the core side until write-back
// RegisterAmo adds one cycle of atomic latency to cut the read-to-write path
`timescale 1ns/1ps

module amo_sequencer #(
  parameter int unsigned AddrWidth   = 32,
  parameter bit          RegisterAmo = 1'b0
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // core request side
  input  logic                           in_valid_i,
  input  logic [AddrWidth-1:0]           in_address_i,
  input  tcdm_pkg::amo_op_e              in_amo_i,
  input  logic                           in_write_i,
  input  logic [tcdm_pkg::DataWidth-1:0] in_wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0]   in_be_i,
  output logic                           in_ready_o,
  // from response path and alu
  input  logic                           resp_stall_i,
  input  logic [tcdm_pkg::DataWidth-1:0] amo_result_i,
  // to response path and alu
  output logic                           rd_issue_o,
  output tcdm_pkg::amo_op_e              amo_op_o,
  output logic [tcdm_pkg::DataWidth-1:0] amo_operand_o,
  // bank side
  output logic                           out_req_o,
  output logic [AddrWidth-1:0]           out_add_o,
  output logic                           out_write_o,
  output logic [tcdm_pkg::DataWidth-1:0] out_wdata_o,
  output logic [tcdm_pkg::BeWidth-1:0]   out_be_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_do_amo,
    st_write_back
  } state_e;

  state_e state_q, state_d;

  // latched atomic request
  tcdm_pkg::amo_op_e              amo_op_q;
  logic [AddrWidth-1:0]           addr_q;
  logic [tcdm_pkg::DataWidth-1:0] operand_q;

  logic                           load_amo;
  // bank is taken by the atomic write-back this cycle
  logic                           claim_bank;
  // word written back by the atomic
  logic [tcdm_pkg::DataWidth-1:0] wb_data;

  // ------------------------------------------------------------
  // write-back data
  // ------------------------------------------------------------

  if (RegisterAmo) begin : gen_amo_reg
    logic [tcdm_pkg::DataWidth-1:0] amo_result_q;

    // old word arrives in do_amo, result is held for the next cycle
    always_ff @(posedge clk_i) begin
      if (state_q == st_do_amo) begin
        amo_result_q <= amo_result_i;
      end
    end

    assign wb_data    = amo_result_q;
    assign claim_bank = (state_q == st_write_back);
  end else begin : gen_amo_comb
    // write straight from the alu in the cycle the old word arrives
    assign wb_data    = amo_result_i;
    assign claim_bank = (state_q == st_do_amo);
  end

  // ------------------------------------------------------------
  // request path and fsm
  // ------------------------------------------------------------

  always_comb begin
    // requests pass through to the bank by default
    in_ready_o  = !resp_stall_i;
    out_req_o   = in_valid_i && !resp_stall_i;
    out_add_o   = in_address_i;
    out_write_o = in_write_i;
    out_wdata_o = in_wdata_i;
    out_be_o    = in_be_i;
    state_d     = state_q;
    load_amo    = 1'b0;

    case (state_q)
      st_idle: begin
        // atomic accepted, its read goes out now
        if (out_req_o && !in_write_i && (in_amo_i != tcdm_pkg::amo_none)) begin
          load_amo = 1'b1;
          state_d  = st_do_amo;
        end
      end
      st_do_amo: begin
        in_ready_o = 1'b0;
        out_req_o  = 1'b0;
        state_d    = RegisterAmo ? st_write_back : st_idle;
      end
      st_write_back: begin
        in_ready_o = 1'b0;
        out_req_o  = 1'b0;
        state_d    = st_idle;
      end
      default: state_d = st_idle;
    endcase

    // atomic commit is always a full word write
    if (claim_bank) begin
      out_req_o   = 1'b1;
      out_write_o = 1'b1;
      out_add_o   = addr_q;
      out_wdata_o = wb_data;
      out_be_o    = '1;
    end
  end

  // every accepted load or atomic reads the bank this cycle
  assign rd_issue_o = in_valid_i && in_ready_o && !in_write_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= st_idle;
      amo_op_q <= tcdm_pkg::amo_none;
    end else begin
      state_q <= state_d;
      if (load_amo) begin
        amo_op_q <= in_amo_i;
      end
    end
  end

  // address and operand only matter while the fsm is busy
  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      addr_q    <= in_address_i;
      operand_q <= in_wdata_i;
    end
  end

  assign amo_op_o      = amo_op_q;
  assign amo_operand_o = operand_q;

endmodule

/* design/resp_buffer.sv */
// bank data must arrive exactly one cycle after rd_issue_i
// holds at most one waiting word, the request side stalls while it waits
`timescale 1ns/1ps

module resp_buffer #(
  parameter int unsigned MetaWidth = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // request side
  input  logic                           rd_issue_i,
  input  logic [MetaWidth-1:0]           in_meta_i,
  // bank read data
  input  logic [tcdm_pkg::DataWidth-1:0] out_rdata_i,
  // core response side
  input  logic                           in_ready_i,
  output logic                           in_valid_o,
  output logic [tcdm_pkg::DataWidth-1:0] in_rdata_o,
  output logic [MetaWidth-1:0]           in_meta_o,
  output logic                           resp_stall_o
);

  // bank word is on out_rdata_i this cycle
  logic                           gnt_q;

  // two-entry tag fifo
  logic [MetaWidth-1:0]           meta_q [2];
  logic                           meta_wr_ptr_q;
  logic                           meta_rd_ptr_q;
  logic [1:0]                     meta_cnt_q;
  logic                           meta_valid;

  // one-entry fall-through register for the word
  logic                           rdata_full_q;
  logic [tcdm_pkg::DataWidth-1:0] rdata_q;
  logic                           rdata_valid;

  logic                           pop_resp;

  // ------------------------------------------------------------
  // grant
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= rd_issue_i;
    end
  end

  // ------------------------------------------------------------
  // tag fifo
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_wr_ptr_q <= 1'b0;
      meta_rd_ptr_q <= 1'b0;
      meta_cnt_q    <= 2'd0;
    end else begin
      if (rd_issue_i) begin
        meta_wr_ptr_q <= ~meta_wr_ptr_q;
      end
      if (pop_resp) begin
        meta_rd_ptr_q <= ~meta_rd_ptr_q;
      end
      // push and pop together leave the count unchanged
      case ({rd_issue_i, pop_resp})
        2'b10:   meta_cnt_q <= meta_cnt_q + 2'd1;
        2'b01:   meta_cnt_q <= meta_cnt_q - 2'd1;
        default: meta_cnt_q <= meta_cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_issue_i) begin
      meta_q[meta_wr_ptr_q] <= in_meta_i;
    end
  end

  assign meta_valid = (meta_cnt_q != 2'd0);
  assign in_meta_o  = meta_q[meta_rd_ptr_q];

  // ------------------------------------------------------------
  // read data register
  // ------------------------------------------------------------

  // keep the word only if the core does not take it at once
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_full_q <= 1'b0;
    end else if (rdata_full_q) begin
      if (pop_resp) begin
        rdata_full_q <= 1'b0;
      end
    end else if (gnt_q && !pop_resp) begin
      rdata_full_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rdata_full_q && gnt_q) begin
      rdata_q <= out_rdata_i;
    end
  end

  assign rdata_valid = rdata_full_q || gnt_q;
  assign in_rdata_o  = rdata_full_q ? rdata_q : out_rdata_i;

  // ------------------------------------------------------------
  // handshake
  // ------------------------------------------------------------

  // word always lands after its tag, so both must be present
  assign in_valid_o   = meta_valid && rdata_valid;
  assign pop_resp     = in_valid_o && in_ready_i;
  assign resp_stall_o = in_valid_o && !in_ready_i;

endmodule

/* design/tcdm_adapter.sv */
// needs sole access to one single-port bank with one-cycle read latency
// no lr/sc support, those op codes must never be issued
`timescale 1ns/1ps

module tcdm_adapter #(
  parameter int unsigned AddrWidth   = 32,
  parameter int unsigned MetaWidth   = 8,
  parameter bit          RegisterAmo = 1'b0
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // core request
  input  logic                           in_valid_i,
  output logic                           in_ready_o,
  input  logic [AddrWidth-1:0]           in_address_i,
  input  tcdm_pkg::amo_op_e              in_amo_i,
  input  logic                           in_write_i,
  input  logic [tcdm_pkg::DataWidth-1:0] in_wdata_i,
  input  logic [MetaWidth-1:0]           in_meta_i,
  input  logic [tcdm_pkg::BeWidth-1:0]   in_be_i,
  // core response
  output logic                           in_valid_o,
  input  logic                           in_ready_i,
  output logic [tcdm_pkg::DataWidth-1:0] in_rdata_o,
  output logic [MetaWidth-1:0]           in_meta_o,
  // bank
  output logic                           out_req_o,
  output logic [AddrWidth-1:0]           out_add_o,
  output logic                           out_write_o,
  output logic [tcdm_pkg::DataWidth-1:0] out_wdata_o,
  output logic [tcdm_pkg::BeWidth-1:0]   out_be_o,
  input  logic [tcdm_pkg::DataWidth-1:0] out_rdata_i
);

  logic                           rd_issue;
  logic                           resp_stall;
  tcdm_pkg::amo_op_e              amo_op;
  logic [tcdm_pkg::DataWidth-1:0] amo_operand;
  logic [tcdm_pkg::DataWidth-1:0] amo_result;

  // request path and atomic fsm
  amo_sequencer #(
    .AddrWidth  (AddrWidth),
    .RegisterAmo(RegisterAmo)
  ) u_amo_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_address_i (in_address_i),
    .in_amo_i     (in_amo_i),
    .in_write_i   (in_write_i),
    .in_wdata_i   (in_wdata_i),
    .in_be_i      (in_be_i),
    .in_ready_o   (in_ready_o),
    .resp_stall_i (resp_stall),
    .amo_result_i (amo_result),
    .rd_issue_o   (rd_issue),
    .amo_op_o     (amo_op),
    .amo_operand_o(amo_operand),
    .out_req_o    (out_req_o),
    .out_add_o    (out_add_o),
    .out_write_o  (out_write_o),
    .out_wdata_o  (out_wdata_o),
    .out_be_o     (out_be_o)
  );

  // old word comes straight from the bank
  amo_alu u_amo_alu (
    .amo_op_i     (amo_op),
    .operand_mem_i(out_rdata_i),
    .operand_req_i(amo_operand),
    .result_o     (amo_result)
  );

  // response path
  resp_buffer #(
    .MetaWidth(MetaWidth)
  ) u_resp_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_issue_i  (rd_issue),
    .in_meta_i   (in_meta_i),
    .out_rdata_i (out_rdata_i),
    .in_ready_i  (in_ready_i),
    .in_valid_o  (in_valid_o),
    .in_rdata_o  (in_rdata_o),
    .in_meta_o   (in_meta_o),
    .resp_stall_o(resp_stall)
  );

endmodule

/* sim/sram_model.sv */
// behavioural bank, read data appears one cycle after a read request and then holds
// word index comes from the byte address, address bits above the depth are ignored
`timescale 1ns/1ps

module sram_model #(
  parameter int unsigned Depth     = 64,
  parameter int unsigned AddrWidth = 32
) (
  input  logic                           clk_i,
  input  logic                           req_i,
  input  logic [AddrWidth-1:0]           addr_i,
  input  logic                           write_i,
  input  logic [tcdm_pkg::DataWidth-1:0] wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0]   be_i,
  output logic [tcdm_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned IdxWidth = $clog2(Depth);

  logic [tcdm_pkg::DataWidth-1:0] mem [Depth];
  logic [IdxWidth-1:0]            idx;

  // byte address, two low bits select the byte inside the word
  assign idx = addr_i[IdxWidth+1:2];

  always @(posedge clk_i) begin
    if (req_i && write_i) begin
      for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
        if (be_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end else if (req_i) begin
      rdata_o <= mem[idx];
    end
  end

endmodule

/* sim/tcdm_adapter_properties.sv */
// protocol checks on the core response and bank sides of every tcdm_adapter
// prop_errors holds the number of failed checks
`timescale 1ns/1ps

module tcdm_adapter_properties #(
  parameter int unsigned MetaWidth = 8
) (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           in_ready_o,
  input logic                           in_valid_o,
  input logic                           in_ready_i,
  input logic [tcdm_pkg::DataWidth-1:0] in_rdata_o,
  input logic [MetaWidth-1:0]           in_meta_o,
  input logic                           out_req_o,
  input logic                           out_write_o,
  input logic [tcdm_pkg::BeWidth-1:0]   out_be_o
);

  int unsigned prop_errors = 0;

  // ------------------------------------------------------------
  // response side
  // ------------------------------------------------------------

  // a waiting response keeps word and tag until taken
  a_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_o && !in_ready_i |=> in_valid_o && $stable(in_rdata_o) && $stable(in_meta_o))
  else begin
    $error("response changed while held against in_ready_i");
    prop_errors++;
  end

  // no new request while a response waits
  a_stall_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_o && !in_ready_i |-> !in_ready_o)
  else begin
    $error("in_ready_o high while a response waits");
    prop_errors++;
  end

  // ------------------------------------------------------------
  // bank side and reset
  // ------------------------------------------------------------

  // only the atomic write-back writes while the core is blocked
  a_blocked_write_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_req_o && out_write_o && !in_ready_o |-> out_be_o == '1)
  else begin
    $error("bank write without full byte enables while in_ready_o is low");
    prop_errors++;
  end

  // first cycle out of reset is quiet
  a_reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !in_valid_o && !out_req_o && in_ready_o)
  else begin
    $error("adapter outputs not quiet after reset");
    prop_errors++;
  end

endmodule

bind tcdm_adapter tcdm_adapter_properties #(
  .MetaWidth(MetaWidth)
) u_properties (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .in_ready_o (in_ready_o),
  .in_valid_o (in_valid_o),
  .in_ready_i (in_ready_i),
  .in_rdata_o (in_rdata_o),
  .in_meta_o  (in_meta_o),
  .out_req_o  (out_req_o),
  .out_write_o(out_write_o),
  .out_be_o   (out_be_o)
);

/* sim/tb_tcdm_adapter.sv */
// directed then random traffic into the adapter with RegisterAmo set and random response stalls
// addresses are word aligned byte addresses into a 64-word bank
`timescale 1ns/1ps

module tb_tcdm_adapter;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned MetaWidth = 8;
  localparam int unsigned MemDepth  = 64;
  localparam int unsigned IdxWidth  = $clog2(MemDepth);
  localparam int unsigned NumOps    = 300;
  // 20 cycles per op is far above the few that a stalled op needs
  localparam int unsigned MaxCycles = 20 * NumOps + 100;
  localparam int unsigned DW        = tcdm_pkg::DataWidth;

  int seed       = 32'h6bae5a66;
  int stall_seed = 32'h6bae5a66;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         in_valid_i;
  logic                         in_ready_o;
  logic [AddrWidth-1:0]         in_address_i;
  tcdm_pkg::amo_op_e            in_amo_i;
  logic                         in_write_i;
  logic [DW-1:0]                in_wdata_i;
  logic [MetaWidth-1:0]         in_meta_i;
  logic [tcdm_pkg::BeWidth-1:0] in_be_i;
  logic                         in_valid_o;
  logic                         in_ready_i;
  logic [DW-1:0]                in_rdata_o;
  logic [MetaWidth-1:0]         in_meta_o;
  logic                         out_req_o;
  logic [AddrWidth-1:0]         out_add_o;
  logic                         out_write_o;
  logic [DW-1:0]                out_wdata_o;
  logic [tcdm_pkg::BeWidth-1:0] out_be_o;
  logic [DW-1:0]                out_rdata_i;

  // reference memory and expected responses in request order
  logic [DW-1:0]        ref_mem [MemDepth];
  logic [DW-1:0]        exp_rdata_q [$];
  logic [MetaWidth-1:0] exp_meta_q [$];
  logic [DW-1:0]        exp_word;
  logic [MetaWidth-1:0] exp_tag;
  logic [IdxWidth-1:0]  widx;

  int unsigned check_errors = 0;
  int unsigned flow_errors  = 0;
  int unsigned cycle_cnt    = 0;

  tcdm_adapter #(
    .AddrWidth  (AddrWidth),
    .MetaWidth  (MetaWidth),
    .RegisterAmo(1'b1)
  ) u_dut (
    .clk_i, .rst_ni, .in_valid_i, .in_ready_o, .in_address_i, .in_amo_i, .in_write_i,
    .in_wdata_i, .in_meta_i, .in_be_i, .in_valid_o, .in_ready_i, .in_rdata_o, .in_meta_o,
    .out_req_o, .out_add_o, .out_write_o, .out_wdata_o, .out_be_o, .out_rdata_i
  );

  sram_model #(
    .Depth    (MemDepth),
    .AddrWidth(AddrWidth)
  ) u_bank (
    .clk_i  (clk_i),
    .req_i  (out_req_o),
    .addr_i (out_add_o),
    .write_i(out_write_o),
    .wdata_i(out_wdata_o),
    .be_i   (out_be_o),
    .rdata_o(out_rdata_i)
  );

  always #50 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // reference rules
  // ------------------------------------------------------------

  // preload image where every index bit changes the word
  function automatic logic [DW-1:0] fill_word(input int unsigned idx);
    return ((32'(idx) + 32'd1) * 32'h9e37_79b1) ^ (32'(idx) << 26);
  endfunction

  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_word,
      input logic [DW-1:0] wdata, input logic [tcdm_pkg::BeWidth-1:0] be);
    logic [DW-1:0] merged;
    merged = old_word;
    for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return merged;
  endfunction

  function automatic logic [DW-1:0] amo_expect(input tcdm_pkg::amo_op_e op,
      input logic [DW-1:0] old_word, input logic [DW-1:0] operand);
    logic [DW-1:0] result;
    case (op)
      tcdm_pkg::amo_swap: result = operand;
      tcdm_pkg::amo_add:  result = old_word + operand;
      tcdm_pkg::amo_and:  result = old_word & operand;
      tcdm_pkg::amo_or:   result = old_word | operand;
      tcdm_pkg::amo_xor:  result = old_word ^ operand;
      tcdm_pkg::amo_max:  result = ($signed(old_word) > $signed(operand)) ? old_word : operand;
      tcdm_pkg::amo_min:  result = ($signed(old_word) < $signed(operand)) ? old_word : operand;
      tcdm_pkg::amo_maxu: result = (old_word > operand) ? old_word : operand;
      tcdm_pkg::amo_minu: result = (old_word < operand) ? old_word : operand;
      default:            result = old_word;
    endcase
    return result;
  endfunction

  task automatic report_mismatch(input string sig, input logic [DW-1:0] expected,
      input logic [DW-1:0] actual);
    $display("** Error @ %0t ns: %s expected %h, got %h", $time, sig, expected, actual);
    check_errors++;
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  // holds the request until it is seen accepted mid-cycle
  task automatic send_req(input logic write, input tcdm_pkg::amo_op_e op,
      input int unsigned idx, input logic [DW-1:0] wdata,
      input logic [tcdm_pkg::BeWidth-1:0] be, input logic [MetaWidth-1:0] tag);
    in_valid_i   = 1'b1;
    in_write_i   = write;
    in_amo_i     = op;
    in_address_i = AddrWidth'(idx << 2);
    in_wdata_i   = wdata;
    in_be_i      = be;
    in_meta_i    = tag;
    forever begin
      @(negedge clk_i);
      if (in_ready_o) begin
        break;
      end
    end
    @(posedge clk_i);
    #1;
    in_valid_i = 1'b0;
  endtask

  // store a start word, run one atomic on it, read the result back
  task automatic check_amo(input tcdm_pkg::amo_op_e op, input int unsigned idx,
      input logic [DW-1:0] init, input logic [DW-1:0] operand);
    send_req(1'b1, tcdm_pkg::amo_none, idx, init, '1, '0);
    send_req(1'b0, op, idx, operand, '1, MetaWidth'(8'h80 + idx));
    send_req(1'b0, tcdm_pkg::amo_none, idx, '0, '0, MetaWidth'(8'hc0 + idx));
  endtask

  // response stalls in about one cycle of four
  always @(posedge clk_i) begin
    #1;
    if (rst_ni) begin
      in_ready_i = ($unsigned($random(stall_seed)) % 4) != 0;
    end
  end

  // ------------------------------------------------------------
  // monitor sampled mid-cycle where all inputs have settled
  // ------------------------------------------------------------

  always @(negedge clk_i) begin
    if (rst_ni) begin
      // taken response is checked before a new request is queued
      if (in_valid_o && in_ready_i) begin
        if (exp_rdata_q.size() == 0) begin
          $display("Response taken at %0t ns with no load or atomic outstanding", $time);
          flow_errors++;
        end else begin
          exp_word = exp_rdata_q.pop_front();
          exp_tag  = exp_meta_q.pop_front();
          assert (in_rdata_o === exp_word)
          else report_mismatch("in_rdata_o", exp_word, in_rdata_o);
          assert (in_meta_o === exp_tag)
          else report_mismatch("in_meta_o", DW'(exp_tag), DW'(in_meta_o));
        end
      end
      if (in_valid_i && in_ready_o) begin
        widx = in_address_i[IdxWidth+1:2];
        if (in_write_i) begin
          ref_mem[widx] = merge_bytes(ref_mem[widx], in_wdata_i, in_be_i);
        end else begin
          exp_rdata_q.push_back(ref_mem[widx]);
          exp_meta_q.push_back(in_meta_i);
          ref_mem[widx] = amo_expect(in_amo_i, ref_mem[widx], in_wdata_i);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout after %0d cycles with %0d responses outstanding",
               cycle_cnt, exp_rdata_q.size());
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    int unsigned          kind;
    int unsigned          idx;
    logic [DW-1:0]        data;
    logic [MetaWidth-1:0] tag;
    tcdm_pkg::amo_op_e    op;

    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    in_valid_i   = 1'b0;
    in_address_i = '0;
    in_amo_i     = tcdm_pkg::amo_none;
    in_write_i   = 1'b0;
    in_wdata_i   = '0;
    in_meta_i    = '0;
    in_be_i      = '0;
    in_ready_i   = 1'b1;
    for (int i = 0; i < MemDepth; i++) begin
      ref_mem[i]    = fill_word(i);
      u_bank.mem[i] = fill_word(i);
    end

    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (in_valid_o === 1'b0) else report_mismatch("in_valid_o", '0, DW'(in_valid_o));
    assert (out_req_o === 1'b0) else report_mismatch("out_req_o", '0, DW'(out_req_o));
    assert (in_ready_o === 1'b1) else report_mismatch("in_ready_o", 1, DW'(in_ready_o));
    @(posedge clk_i);
    #1;

    // first reads see the preloaded image
    for (int i = 0; i < 4; i++) begin
      send_req(1'b0, tcdm_pkg::amo_none, i * 5, '0, '0, MetaWidth'(i + 1));
    end
    // partial stores each followed by a read of the merged word
    send_req(1'b1, tcdm_pkg::amo_none, 40, 32'hdead_beef, 4'b0101, '0);
    send_req(1'b0, tcdm_pkg::amo_none, 40, '0, '0, 8'h11);
    send_req(1'b1, tcdm_pkg::amo_none, 40, 32'h0123_4567, 4'b1000, '0);
    send_req(1'b0, tcdm_pkg::amo_none, 40, '0, '0, 8'h12);
    send_req(1'b1, tcdm_pkg::amo_none, 40, 32'hffff_ffff, 4'b0000, '0);
    send_req(1'b0, tcdm_pkg::amo_none, 40, '0, '0, 8'h13);
    // every atomic with a negative then a positive start word
    for (int k = 1; k <= 9; k++) begin
      check_amo(tcdm_pkg::amo_op_e'(k), 47 + k, 32'hf000_1234, 32'h1765_4321);
      check_amo(tcdm_pkg::amo_op_e'(k), 47 + k, 32'h0000_0042, 32'hffff_fff0);
    end

    for (int n = 0; n < NumOps; n++) begin
      kind = $unsigned($random(seed)) % 4;
      idx  = $unsigned($random(seed)) % 16;
      data = $random(seed);
      tag  = MetaWidth'($random(seed));
      op   = tcdm_pkg::amo_op_e'(1 + $unsigned($random(seed)) % 9);
      case (kind)
        0: send_req(1'b0, tcdm_pkg::amo_none, idx, data, '0, tag);
        1: send_req(1'b1, tcdm_pkg::amo_none, idx, data, 4'($random(seed)), tag);
        default: send_req(1'b0, op, idx, data, '1, tag);
      endcase
    end

    // let every response drain and the last write-back land
    while (exp_rdata_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);

    $display("Errors: value %0d, flow %0d, property %0d",
             check_errors, flow_errors, u_dut.u_properties.prop_errors);
    if (check_errors + flow_errors + u_dut.u_properties.prop_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* build.f */
design/tcdm_pkg.sv
design/amo_alu.sv
design/amo_sequencer.sv
design/resp_buffer.sv
design/tcdm_adapter.sv
sim/sram_model.sv
sim/tcdm_adapter_properties.sv
sim/tb_tcdm_adapter.sv
